// File: sim.f
hdl/aznable_pkg.sv
hdl/bus_decoder.sv
hdl/io_readback.sv
hdl/ms_timer.sv
hdl/system_control.sv
hdl/work_ram.sv
hdl/layer_mixer.sv
hdl/system_bus.sv
tests/system_bus_tb.sv

// File: Bender.yml
package:
  name: system_bus

sources:
  - hdl/aznable_pkg.sv
  - hdl/bus_decoder.sv
  - hdl/io_readback.sv
  - hdl/ms_timer.sv
  - hdl/system_control.sv
  - hdl/work_ram.sv
  - hdl/layer_mixer.sv
  - hdl/system_bus.sv
  - target: simulation
    files:
      - tests/system_bus_tb.sv

// File: tests/system_bus_tb.sv
`timescale 1ns/10ps

module system_bus_tb;
	import aznable_pkg::*;

	localparam int TIMER_K1 = 3;
	localparam int TIMER_K2 = 9;
	localparam int WKRAM_WRITES = 200;
	localparam int MIX_STEPS = 64;
	// rough cycle budget of every test in order
	localparam int TEST_CYCLES = 16 + (8 * 256 + 4) + (WKRAM_WRITES * 3 + 4)
		+ ((TIMER_K1 + TIMER_K2) * 24 + 20) + 30 + 2 * (MIX_STEPS + 4);

	logic clk_24;
	logic reset;
	addr_t cpu_addr;
	byte_t cpu_dout;
	logic cpu_wr_n;
	byte_t cpu_din;
	logic hs, vs, hb, vb;
	logic pause;
	logic menu;
	logic pause_system;
	logic [191:0] joystick;
	logic [95:0] analog_l;
	logic [95:0] analog_r;
	logic [47:0] paddle;
	logic [95:0] spinner;
	logic [10:0] ps2_key;
	logic [47:0] ps2_mouse;
	logic [32:0] timestamp;
	rgb_t charmap_rgb, sprite_rgb, tilemap_rgb;
	logic charmap_a, sprite_a, tilemap_a;
	logic sf_on1, sf_on2, sf_on3;
	byte_t sf_star1, sf_star2, sf_star3;
	byte_t vga_r, vga_g, vga_b;

	// testbench models of the DUT state
	byte_t ram_m [int];
	logic menu_trig_m = 1'b0;
	logic sprite_high_m = 1'b0;

	// reads in flight are compared one cycle after the address goes out
	byte_t exp_q [$];
	string name_q [$];
	logic rd_issue = 1'b0;
	logic rd_due = 1'b0;
	logic mix_check = 1'b0;

	int byte_errors = 0;
	int rgb_errors = 0;
	int flag_errors = 0;
	int other_errors = 0;

	system_bus #(
		.CYCLES_PER_MS(24)
	) dut0 (
		.clk_24(clk_24), .reset(reset),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_wr_n(cpu_wr_n), .cpu_din(cpu_din),
		.hs(hs), .vs(vs), .hb(hb), .vb(vb),
		.pause(pause), .menu(menu), .pause_system(pause_system),
		.joystick(joystick), .analog_l(analog_l), .analog_r(analog_r),
		.paddle(paddle), .spinner(spinner), .ps2_key(ps2_key),
		.ps2_mouse(ps2_mouse), .timestamp(timestamp),
		.charmap_rgb(charmap_rgb), .sprite_rgb(sprite_rgb), .tilemap_rgb(tilemap_rgb),
		.charmap_a(charmap_a), .sprite_a(sprite_a), .tilemap_a(tilemap_a),
		.sf_on1(sf_on1), .sf_on2(sf_on2), .sf_on3(sf_on3),
		.sf_star1(sf_star1), .sf_star2(sf_star2), .sf_star3(sf_star3),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #5 clk_24 = ~clk_24;
	end

	// expected read data rebuilt from the memory map rules
	// (the timer page has its own test since the count is not modelled)
	function automatic byte_t expected_read(addr_t a);
		logic [255:0] vec;
		int nbytes;
		int idx;
		vec = '0;
		nbytes = 1;
		if (a == IN0_ADDR)
			return {hs, vs, hb, vb, 2'b10, menu, 1'b0};
		if (a == MENU_ADDR)
			return {8{menu_trig_m}};
		if (a[15:14] == WKRAM_BASE[15:14])
			return ram_m.exists(int'(a[13:0])) ? ram_m[int'(a[13:0])] : 8'h00;
		case (a[15:8])
			JOYSTICK_BASE[15:8]:
			begin
				vec = joystick;
				nbytes = 24;
			end
			ANALOG_L_BASE[15:8]:
			begin
				vec = analog_l;
				nbytes = 12;
			end
			ANALOG_R_BASE[15:8]:
			begin
				vec = analog_r;
				nbytes = 12;
			end
			PADDLE_BASE[15:8]:
			begin
				vec = paddle;
				nbytes = 6;
			end
			SPINNER_BASE[15:8]:
			begin
				vec = spinner;
				nbytes = 12;
			end
			PS2_KEY_BASE[15:8]:
			begin
				vec = ps2_key;
				nbytes = 2;
			end
			PS2_MOUSE_BASE[15:8]:
			begin
				vec = ps2_mouse;
				nbytes = 6;
			end
			TIMESTAMP_BASE[15:8]:
			begin
				vec = timestamp;
				nbytes = 5;
			end
			default: return 8'h00;
		endcase
		// byte index wraps at the power of two that covers the vector
		idx = int'(a[7:0]) & ((1 << $clog2(nbytes)) - 1);
		return vec[idx * 8 +: 8];
	endfunction

	function automatic rgb_t expected_rgb();
		byte_t grey;
		rgb_t stars;
		grey = sf_on1 ? sf_star1 : sf_on2 ? (sf_star2 & 8'h7f) :
			sf_on3 ? (sf_star3 & 8'h3f) : 8'h00;
		stars = {grey, grey, grey};
		if (sprite_high_m)
			return sprite_a ? sprite_rgb : charmap_a ? charmap_rgb :
				tilemap_a ? tilemap_rgb : stars;
		return charmap_a ? charmap_rgb : sprite_a ? sprite_rgb :
			tilemap_a ? tilemap_rgb : stars;
	endfunction

	function automatic logic [255:0] rand_vec();
		logic [255:0] v;
		for (int i = 0; i < 8; i++)
			v[i * 32 +: 32] = $urandom;
		return v;
	endfunction

	task automatic check_byte(string name, byte_t expected, byte_t actual);
		if (actual !== expected)
		begin
			byte_errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_rgb(string name, rgb_t expected, rgb_t actual);
		if (actual !== expected)
		begin
			rgb_errors++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			flag_errors++;
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
		end
	endtask

	always @(posedge clk_24)
		rd_due <= rd_issue;

	// outputs are stable at the falling edge
	always @(negedge clk_24)
	begin
		if (rd_due)
		begin
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("read data came back with no expected value queued");
			end
			else
				check_byte(name_q.pop_front(), exp_q.pop_front(), cpu_din);
		end
		if (mix_check)
			check_rgb("layer_mixer", expected_rgb(), {vga_b, vga_g, vga_r});
	end

	task automatic step();
		@(posedge clk_24);
		#1;
	endtask

	task automatic bus_write(addr_t a, byte_t d);
		step();
		cpu_addr = a;
		cpu_dout = d;
		cpu_wr_n = 1'b0;
		if (a == MENU_ADDR)
			menu_trig_m = 1'b0;
		if (a == VIDEO_CTL_ADDR)
			sprite_high_m = d[0];
		if (a[15:14] == WKRAM_BASE[15:14])
			ram_m[int'(a[13:0])] = d;
		step();
		cpu_wr_n = 1'b1;
	endtask

	task automatic read_issue(addr_t a, string name);
		step();
		cpu_addr = a;
		cpu_wr_n = 1'b1;
		exp_q.push_back(expected_read(a));
		name_q.push_back(name);
		rd_issue = 1'b1;
	endtask

	task automatic read_drain();
		step();
		rd_issue = 1'b0;
		cpu_addr = 16'h0000;
		step();
	endtask

	task automatic read_now(addr_t a, output byte_t v);
		step();
		cpu_addr = a;
		cpu_wr_n = 1'b1;
		@(posedge clk_24);
		@(negedge clk_24);
		v = cpu_din;
	endtask

	task automatic timer_test(int k);
		byte_t lo;
		byte_t hi;
		bus_write(TIMER_BASE, 8'h00);
		repeat (k * 24) step();
		read_now(TIMER_BASE, lo);
		read_now(TIMER_BASE + 16'd1, hi);
		// one extra tick may land during the read
		check_byte("timer_low", (lo === byte_t'(k + 1)) ? byte_t'(k + 1) : byte_t'(k), lo);
		check_byte("timer_high", 8'h00, hi);
	endtask

	task automatic randomize_layers();
		charmap_rgb = $urandom;
		sprite_rgb = $urandom;
		tilemap_rgb = $urandom;
		{charmap_a, sprite_a, tilemap_a} = $urandom;
		{sf_on1, sf_on2, sf_on3} = $urandom;
		sf_star1 = $urandom;
		sf_star2 = $urandom;
		sf_star3 = $urandom;
	endtask

	initial
	begin
		addr_t wr_addr [WKRAM_WRITES];
		void'($urandom(32'hc1fa));
		reset = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_wr_n = 1'b1;
		{hs, vs, hb, vb} = 4'b0;
		pause = 1'b0;
		menu = 1'b0;
		{joystick, analog_l, analog_r, paddle} = '0;
		{spinner, ps2_key, ps2_mouse, timestamp} = '0;
		{charmap_rgb, sprite_rgb, tilemap_rgb} = '0;
		{charmap_a, sprite_a, tilemap_a, sf_on1, sf_on2, sf_on3} = '0;
		{sf_star1, sf_star2, sf_star3} = '0;
		repeat (16) @(posedge clk_24);
		#1;
		reset = 1'b0;

		// input readback over every page
		joystick = rand_vec();
		analog_l = rand_vec();
		analog_r = rand_vec();
		paddle = rand_vec();
		spinner = rand_vec();
		ps2_key = rand_vec();
		ps2_mouse = rand_vec();
		timestamp = rand_vec();
		{hs, vs, hb, vb} = $urandom;
		read_issue(IN0_ADDR, "in0");
		for (int p = 'h81; p <= 'h88; p++)
			for (int lo = 0; lo < 256; lo++)
				read_issue({p[7:0], lo[7:0]}, $sformatf("readback_%02h%02h", p, lo));
		read_drain();

		// work RAM
		for (int i = 0; i < WKRAM_WRITES; i++)
		begin
			wr_addr[i] = WKRAM_BASE | addr_t'($urandom & 16'h3fff);
			bus_write(wr_addr[i], $urandom);
		end
		for (int i = 0; i < WKRAM_WRITES; i++)
			read_issue(wr_addr[i], "wkram");
		read_drain();

		timer_test(TIMER_K1);
		timer_test(TIMER_K2);

		// pause trigger holds until the pause input pulses
		bus_write(PAUSE_ADDR, 8'h00);
		@(negedge clk_24);
		check_flag("pause_set", 1'b1, pause_system);
		repeat (5) step();
		@(negedge clk_24);
		check_flag("pause_hold", 1'b1, pause_system);
		step();
		pause = 1'b1;
		step();
		pause = 1'b0;
		@(negedge clk_24);
		check_flag("pause_release", 1'b0, pause_system);
		// with the trigger clear the pause input alone reaches pause_system
		step();
		pause = 1'b1;
		@(negedge clk_24);
		check_flag("pause_input", 1'b1, pause_system);
		step();
		pause = 1'b0;

		// menu pulse then acknowledge by a write
		step();
		menu = 1'b1;
		step();
		menu = 1'b0;
		menu_trig_m = 1'b1;
		read_issue(MENU_ADDR, "menu_set");
		read_drain();
		bus_write(MENU_ADDR, 8'h00);
		read_issue(MENU_ADDR, "menu_ack");
		read_drain();

		// layer mixer with both priorities
		for (int sh = 0; sh < 2; sh++)
		begin
			bus_write(VIDEO_CTL_ADDR, {$urandom, 1'b0} | byte_t'(sh));
			mix_check = 1'b1;
			repeat (MIX_STEPS)
			begin
				step();
				randomize_layers();
			end
			step();
			mix_check = 1'b0;
		end

		step();
		$display("errors: byte %0d rgb %0d flag %0d other %0d",
			byte_errors, rgb_errors, flag_errors, other_errors);
		if (byte_errors + rgb_errors + flag_errors + other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial
	begin
		#(20 * TEST_CYCLES * 10);
		$display("timeout: the tests did not finish within %0d cycles", 20 * TEST_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: hdl/system_bus.sv
`timescale 1ns/10ps

module system_bus #(
	parameter int CYCLES_PER_MS = 24000
) (
	input logic clk_24,
	input logic reset,
	input aznable_pkg::addr_t cpu_addr,
	input aznable_pkg::byte_t cpu_dout,
	input logic cpu_wr_n,
	output aznable_pkg::byte_t cpu_din,
	input logic hs,
	input logic vs,
	input logic hb,
	input logic vb,
	input logic pause,
	input logic menu,
	output logic pause_system,
	input logic [191:0] joystick,
	input logic [95:0] analog_l,
	input logic [95:0] analog_r,
	input logic [47:0] paddle,
	input logic [95:0] spinner,
	input logic [10:0] ps2_key,
	input logic [47:0] ps2_mouse,
	input logic [32:0] timestamp,
	input aznable_pkg::rgb_t charmap_rgb,
	input aznable_pkg::rgb_t sprite_rgb,
	input aznable_pkg::rgb_t tilemap_rgb,
	input logic charmap_a,
	input logic sprite_a,
	input logic tilemap_a,
	input logic sf_on1,
	input logic sf_on2,
	input logic sf_on3,
	input aznable_pkg::byte_t sf_star1,
	input aznable_pkg::byte_t sf_star2,
	input aznable_pkg::byte_t sf_star3,
	output aznable_pkg::byte_t vga_r,
	output aznable_pkg::byte_t vga_g,
	output aznable_pkg::byte_t vga_b
);
	import aznable_pkg::*;

	rd_src_e rd_src;
	logic timer_clr;
	logic video_ctl_wr;
	logic pause_wr;
	logic menu_wr;
	logic wkram_wr;
	timer_t timer;
	logic sprite_high;
	logic menu_trigger;
	byte_t wkram_q;

	bus_decoder decoder0 (
		.cpu_addr(cpu_addr),
		.cpu_wr_n(cpu_wr_n),
		.rd_src(rd_src),
		.timer_clr(timer_clr),
		.video_ctl_wr(video_ctl_wr),
		.pause_wr(pause_wr),
		.menu_wr(menu_wr),
		.wkram_wr(wkram_wr)
	);

	// status byte, bits 3:2 fixed at 10 and the debug bit held low
	io_readback readback0 (
		.clk_24(clk_24),
		.reset(reset),
		.rd_src(rd_src),
		.cpu_addr(cpu_addr),
		.in0_flags({hs, vs, hb, vb, 2'b10, menu, 1'b0}),
		.joystick(joystick),
		.analog_l(analog_l),
		.analog_r(analog_r),
		.paddle(paddle),
		.spinner(spinner),
		.ps2_key(ps2_key),
		.ps2_mouse(ps2_mouse),
		.timestamp(timestamp),
		.timer(timer),
		.menu_trigger(menu_trigger),
		.wkram_q(wkram_q),
		.cpu_din(cpu_din)
	);

	ms_timer #(
		.CYCLES_PER_MS(CYCLES_PER_MS)
	) timer0 (
		.clk_24(clk_24),
		.reset(reset),
		.timer_clr(timer_clr),
		.timer(timer)
	);

	system_control control0 (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_dout(cpu_dout),
		.video_ctl_wr(video_ctl_wr),
		.pause_wr(pause_wr),
		.menu_wr(menu_wr),
		.pause(pause),
		.menu(menu),
		.sprite_high(sprite_high),
		.pause_system(pause_system),
		.menu_trigger(menu_trigger)
	);

	work_ram wkram0 (
		.clk_24(clk_24),
		.wkram_wr(wkram_wr),
		.addr(cpu_addr[13:0]),
		.data(cpu_dout),
		.q(wkram_q)
	);

	layer_mixer mixer0 (
		.sprite_high(sprite_high),
		.charmap_rgb(charmap_rgb),
		.sprite_rgb(sprite_rgb),
		.tilemap_rgb(tilemap_rgb),
		.charmap_a(charmap_a),
		.sprite_a(sprite_a),
		.tilemap_a(tilemap_a),
		.sf_on1(sf_on1),
		.sf_on2(sf_on2),
		.sf_on3(sf_on3),
		.sf_star1(sf_star1),
		.sf_star2(sf_star2),
		.sf_star3(sf_star3),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

// File: hdl/layer_mixer.sv
`timescale 1ns/10ps

module layer_mixer (
	input logic sprite_high,
	input aznable_pkg::rgb_t charmap_rgb,
	input aznable_pkg::rgb_t sprite_rgb,
	input aznable_pkg::rgb_t tilemap_rgb,
	input logic charmap_a,
	input logic sprite_a,
	input logic tilemap_a,
	input logic sf_on1,
	input logic sf_on2,
	input logic sf_on3,
	input aznable_pkg::byte_t sf_star1,
	input aznable_pkg::byte_t sf_star2,
	input aznable_pkg::byte_t sf_star3,
	output aznable_pkg::byte_t vga_r,
	output aznable_pkg::byte_t vga_g,
	output aznable_pkg::byte_t vga_b
);
	import aznable_pkg::*;

	byte_t star_grey;
	rgb_t star_rgb;
	rgb_t final_rgb;

	// deeper star layers are dimmer
	always_comb
	begin
		if (sf_on1)
			star_grey = sf_star1;
		else if (sf_on2)
			star_grey = {1'b0, sf_star2[6:0]};
		else if (sf_on3)
			star_grey = {2'b0, sf_star3[5:0]};
		else
			star_grey = '0;
	end

	assign star_rgb = {3{star_grey}};

	always_comb
	begin
		if (sprite_high)
			final_rgb = sprite_a ? sprite_rgb :
				charmap_a ? charmap_rgb :
				tilemap_a ? tilemap_rgb : star_rgb;
		else
			final_rgb = charmap_a ? charmap_rgb :
				sprite_a ? sprite_rgb :
				tilemap_a ? tilemap_rgb : star_rgb;
	end

	assign vga_r = final_rgb[7:0];
	assign vga_g = final_rgb[15:8];
	assign vga_b = final_rgb[23:16];

endmodule

// File: hdl/work_ram.sv
`timescale 1ns/10ps

module work_ram (
	input logic clk_24,
	input logic wkram_wr,
	input aznable_pkg::wkram_addr_t addr,
	input aznable_pkg::byte_t data,
	output aznable_pkg::byte_t q
);
	import aznable_pkg::*;

	byte_t mem [0:16383];

	// q shows the old contents on a write cycle
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			mem[addr] <= data;
		q <= mem[addr];
	end

endmodule

// File: hdl/system_control.sv
`timescale 1ns/10ps

module system_control (
	input logic clk_24,
	input logic reset,
	input aznable_pkg::byte_t cpu_dout,
	input logic video_ctl_wr,
	input logic pause_wr,
	input logic menu_wr,
	input logic pause,
	input logic menu,
	output logic sprite_high,
	output logic pause_system,
	output logic menu_trigger
);
	import aznable_pkg::*;

	byte_t video_ctl;
	logic pause_trigger;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			video_ctl <= '0;
			pause_trigger <= 1'b0;
			menu_trigger <= 1'b0;
		end
		else
		begin
			if (video_ctl_wr)
				video_ctl <= cpu_dout;
			// pause input releases the trigger even against a write
			if (pause)
				pause_trigger <= 1'b0;
			else if (pause_wr)
				pause_trigger <= 1'b1;
			// the CPU acknowledges the menu by writing it
			if (menu_wr)
				menu_trigger <= 1'b0;
			else if (menu)
				menu_trigger <= 1'b1;
		end
	end

	// sprites above the charmap when set
	assign sprite_high = video_ctl[0];
	assign pause_system = pause || pause_trigger;

	assert property (@(posedge clk_24) disable iff (reset) pause |-> pause_system)
	else $error("system_control: pause input not reflected");

endmodule

// File: hdl/ms_timer.sv
`timescale 1ns/10ps

module ms_timer #(
	parameter int CYCLES_PER_MS = 24000
) (
	input logic clk_24,
	input logic reset,
	input logic timer_clr,
	output aznable_pkg::timer_t timer
);
	localparam int PRE_W = (CYCLES_PER_MS > 1) ? $clog2(CYCLES_PER_MS) : 1;

	logic [PRE_W-1:0] prescale;

	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clr)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (prescale == PRE_W'(CYCLES_PER_MS - 1))
		begin
			prescale <= '0;
			// wraps past 65535 on its own
			timer <= timer + 1'b1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	assert property (@(posedge clk_24) timer_clr |=> timer == '0)
	else $error("ms_timer: count not cleared after bus write");

endmodule

// File: hdl/io_readback.sv
`timescale 1ns/10ps

module io_readback (
	input logic clk_24,
	input logic reset,
	input aznable_pkg::rd_src_e rd_src,
	input aznable_pkg::addr_t cpu_addr,
	input aznable_pkg::byte_t in0_flags,
	input logic [191:0] joystick,
	input logic [95:0] analog_l,
	input logic [95:0] analog_r,
	input logic [47:0] paddle,
	input logic [95:0] spinner,
	input logic [10:0] ps2_key,
	input logic [47:0] ps2_mouse,
	input logic [32:0] timestamp,
	input aznable_pkg::timer_t timer,
	input logic menu_trigger,
	input aznable_pkg::byte_t wkram_q,
	output aznable_pkg::byte_t cpu_din
);
	import aznable_pkg::*;

	// inputs widened to the span the low address bits can reach
	logic [255:0] joystick_pad;
	logic [127:0] analog_l_pad;
	logic [127:0] analog_r_pad;
	logic [63:0] paddle_pad;
	logic [127:0] spinner_pad;
	logic [15:0] ps2_key_pad;
	logic [63:0] ps2_mouse_pad;
	logic [63:0] timestamp_pad;
	byte_t sel_byte;
	byte_t sel_byte_q;
	rd_src_e rd_src_q;

	assign joystick_pad = {64'b0, joystick};
	assign analog_l_pad = {32'b0, analog_l};
	assign analog_r_pad = {32'b0, analog_r};
	assign paddle_pad = {16'b0, paddle};
	assign spinner_pad = {32'b0, spinner};
	assign ps2_key_pad = {5'b0, ps2_key};
	assign ps2_mouse_pad = {16'b0, ps2_mouse};
	assign timestamp_pad = {31'b0, timestamp};

	always_comb
	begin
		case (rd_src)
			IN0: sel_byte = in0_flags;
			JOYSTICK: sel_byte = joystick_pad[{cpu_addr[4:0], 3'd0} +: 8];
			ANALOG_L: sel_byte = analog_l_pad[{cpu_addr[3:0], 3'd0} +: 8];
			ANALOG_R: sel_byte = analog_r_pad[{cpu_addr[3:0], 3'd0} +: 8];
			PADDLE: sel_byte = paddle_pad[{cpu_addr[2:0], 3'd0} +: 8];
			SPINNER: sel_byte = spinner_pad[{cpu_addr[3:0], 3'd0} +: 8];
			PS2_KEY: sel_byte = ps2_key_pad[{cpu_addr[0], 3'd0} +: 8];
			PS2_MOUSE: sel_byte = ps2_mouse_pad[{cpu_addr[2:0], 3'd0} +: 8];
			TIMESTAMP: sel_byte = timestamp_pad[{cpu_addr[2:0], 3'd0} +: 8];
			TIMER: sel_byte = timer[{cpu_addr[0], 3'd0} +: 8];
			MENU: sel_byte = {8{menu_trigger}};
			default: sel_byte = '0;
		endcase
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			rd_src_q <= NONE;
			sel_byte_q <= '0;
		end
		else
		begin
			rd_src_q <= rd_src;
			sel_byte_q <= sel_byte;
		end
	end

	// the RAM output is already registered, so it lines up with sel_byte_q
	assign cpu_din = (rd_src_q == WKRAM) ? wkram_q : sel_byte_q;

endmodule

// File: hdl/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder (
	input aznable_pkg::addr_t cpu_addr,
	input logic cpu_wr_n,
	output aznable_pkg::rd_src_e rd_src,
	output logic timer_clr,
	output logic video_ctl_wr,
	output logic pause_wr,
	output logic menu_wr,
	output logic wkram_wr
);
	import aznable_pkg::*;

	logic [7:0] page;
	logic wr;
	logic wkram_cs;

	assign page = cpu_addr[15:8];
	assign wr = !cpu_wr_n;
	assign wkram_cs = cpu_addr[15:14] == WKRAM_BASE[15:14];

	// readback source, exact registers first, then the input pages
	always_comb
	begin
		rd_src = NONE;
		if (cpu_addr == IN0_ADDR)
			rd_src = IN0;
		else if (cpu_addr == MENU_ADDR)
			rd_src = MENU;
		else if (wkram_cs)
			rd_src = WKRAM;
		else
		begin
			case (page)
				JOYSTICK_BASE[15:8]: rd_src = JOYSTICK;
				ANALOG_L_BASE[15:8]: rd_src = ANALOG_L;
				ANALOG_R_BASE[15:8]: rd_src = ANALOG_R;
				PADDLE_BASE[15:8]: rd_src = PADDLE;
				SPINNER_BASE[15:8]: rd_src = SPINNER;
				PS2_KEY_BASE[15:8]: rd_src = PS2_KEY;
				PS2_MOUSE_BASE[15:8]: rd_src = PS2_MOUSE;
				TIMESTAMP_BASE[15:8]: rd_src = TIMESTAMP;
				TIMER_BASE[15:8]: rd_src = TIMER;
				default: rd_src = NONE;
			endcase
		end
	end

	// any write into the timer page clears the count
	assign timer_clr = wr && page == TIMER_BASE[15:8];
	assign video_ctl_wr = wr && cpu_addr == VIDEO_CTL_ADDR;
	assign pause_wr = wr && cpu_addr == PAUSE_ADDR;
	assign menu_wr = wr && cpu_addr == MENU_ADDR;
	assign wkram_wr = wr && wkram_cs;

	// no address may hit two write targets
	always_comb
	begin
		assert #0 ($onehot0({timer_clr, video_ctl_wr, pause_wr, menu_wr, wkram_wr}))
		else $error("bus_decoder: overlapping write selects at %h", cpu_addr);
	end

endmodule

// File: hdl/aznable_pkg.sv
package aznable_pkg;

	// widths that carry a meaning on the system bus
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] timer_t;
	// packed as blue, green, red
	typedef logic [23:0] rgb_t;
	typedef logic [13:0] wkram_addr_t;

	// source of the byte returned on a CPU read
	typedef enum logic [3:0]
	{
		NONE,
		IN0,
		JOYSTICK,
		ANALOG_L,
		ANALOG_R,
		PADDLE,
		SPINNER,
		PS2_KEY,
		PS2_MOUSE,
		TIMESTAMP,
		TIMER,
		MENU,
		WKRAM
	} rd_src_e;

	// memory map, single registers
	localparam addr_t IN0_ADDR = 16'h8000;
	localparam addr_t VIDEO_CTL_ADDR = 16'h8001;
	localparam addr_t PAUSE_ADDR = 16'h8A30;
	localparam addr_t MENU_ADDR = 16'h8A31;

	// memory map, 256 byte input pages (only the high byte is decoded)
	localparam addr_t JOYSTICK_BASE = 16'h8100;
	localparam addr_t ANALOG_L_BASE = 16'h8200;
	localparam addr_t ANALOG_R_BASE = 16'h8300;
	localparam addr_t PADDLE_BASE = 16'h8400;
	localparam addr_t SPINNER_BASE = 16'h8500;
	localparam addr_t PS2_KEY_BASE = 16'h8600;
	localparam addr_t PS2_MOUSE_BASE = 16'h8700;
	localparam addr_t TIMESTAMP_BASE = 16'h8800;
	localparam addr_t TIMER_BASE = 16'h8900;

	// work RAM fills the top 16 KB
	localparam addr_t WKRAM_BASE = 16'hC000;

endpackage
